// ==== design/afu_csr_endpoint.sv ====
/*
 * AFU register file reached through request packets.
 * Register 0 is read-only and returns the AFU ID; the rest are plain storage.
 * Every read is answered with one completion, one cycle after its request is taken.
 */
`timescale 1ns/1ns
`include "host_chan_settings.svh"

module afu_csr_endpoint
   (
    input  logic              pClk,
    input  logic              reset,

    input  logic              req_empty,
    output logic              req_pop,
    input  tlp_pkg::t_tlp_req req_data,

    output logic              cpl_push,
    output tlp_pkg::t_tlp_cpl cpl_data
    );

    localparam int NUM_REGS = `HOST_CHAN_NUM_REGS;

    // Register 0 is not stored, so the array starts at 1
    logic [63:0] regs [1:NUM_REGS-1];
    logic        is_read;
    logic        is_write;

    // One request is consumed per cycle whenever one is waiting
    assign req_pop  = !req_empty;
    assign is_read  = req_pop && (req_data.hdr.kind == tlp_pkg::mem_read);
    assign is_write = req_pop && (req_data.hdr.kind == tlp_pkg::mem_write);

    always_ff @(posedge pClk)
    begin
        if (reset)
        begin
            for (int i = 1; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (is_write && (req_data.hdr.addr != '0))
        begin
            // Writes to the ID register fall through here and are lost
            regs[req_data.hdr.addr] <= req_data.data;
        end
    end

    always_ff @(posedge pClk)
    begin
        if (reset)
            cpl_push <= 1'b0;
        else
            cpl_push <= is_read;
    end

    // Completion payload whose tag and address echo the request
    always_ff @(posedge pClk)
    begin
        cpl_data.hdr.kind <= tlp_pkg::completion;
        cpl_data.hdr.tag  <= req_data.hdr.tag;
        cpl_data.hdr.addr <= req_data.hdr.addr;
        if (req_data.hdr.addr == '0)
            cpl_data.data <= tlp_pkg::AFU_ID;
        else
            cpl_data.data <= regs[req_data.hdr.addr];
    end

    // The host never places a completion on the request path
    assert property (@(posedge pClk) disable iff (reset)
        req_pop |-> (req_data.hdr.kind != tlp_pkg::completion));

endmodule

// ==== design/host_chan_emul.sv ====
/*
 * Emulated host channel that fans out the per-port reset and instance number
 * and carries traffic on port 0 only through request and completion FIFOs.
 */
`timescale 1ns/1ns
`include "host_chan_settings.svh"

module host_chan_emul
   (
    input  platform_pkg::t_std_clocks  clocks,

    input  logic                       cmd_valid,
    input  logic                       cmd_write,
    input  tlp_pkg::t_reg_addr         cmd_addr,
    input  logic [63:0]                cmd_data,
    output logic                       cmd_full,

    output logic                       req_empty,
    input  logic                       req_pop,
    output tlp_pkg::t_tlp_req          req_data,
    input  logic                       cpl_push,
    input  tlp_pkg::t_tlp_cpl          cpl_data,

    output logic                       rd_valid,
    output tlp_pkg::t_tlp_tag          rd_tag,
    output logic [63:0]                rd_data,
    output logic                       soft_reset,
    output platform_pkg::t_power_state pwr_state,
    output logic [`HOST_CHAN_NUM_PORTS-1:0] port_reset_n,
    output platform_pkg::t_port_num [`HOST_CHAN_NUM_PORTS-1:0] port_instance
    );

    logic              pClk;
    logic              reset;
    logic              host_req_push;
    tlp_pkg::t_tlp_req host_req_data;
    logic              host_cpl_pop;
    tlp_pkg::t_tlp_cpl host_cpl_data;
    logic              cpl_empty;

    assign pClk  = clocks.pClk.clk;
    assign reset = clocks.pClk.reset;

    // Every port sees the soft reset and learns its own index
    genvar p;
    generate
        for (p = 0; p < `HOST_CHAN_NUM_PORTS; p = p + 1)
        begin : g_port
            assign port_reset_n[p]  = ~soft_reset;
            assign port_instance[p] = platform_pkg::t_port_num'(p);
        end
    endgenerate

    tlp_host_model host_model
       (
        .pClk(pClk),
        .reset(reset),
        .cmd_valid(cmd_valid),
        .cmd_write(cmd_write),
        .cmd_addr(cmd_addr),
        .cmd_data(cmd_data),
        .cmd_full(cmd_full),
        .req_push(host_req_push),
        .req_data(host_req_data),
        .cpl_empty(cpl_empty),
        .cpl_pop(host_cpl_pop),
        .cpl_data(host_cpl_data),
        .rd_valid(rd_valid),
        .rd_tag(rd_tag),
        .rd_data(rd_data),
        .soft_reset(soft_reset),
        .pwr_state(pwr_state)
        );

    // Host to AFU requests on port 0
    tlp_fifo #(.t_payload(tlp_pkg::t_tlp_req)) req_fifo
       (
        .pClk(pClk),
        .reset(reset),
        .push(host_req_push),
        .push_data(host_req_data),
        .pop(req_pop),
        .pop_data(req_data),
        .empty(req_empty)
        );

    // AFU to host completions on port 0
    tlp_fifo #(.t_payload(tlp_pkg::t_tlp_cpl)) cpl_fifo
       (
        .pClk(pClk),
        .reset(reset),
        .push(cpl_push),
        .push_data(cpl_data),
        .pop(host_cpl_pop),
        .pop_data(host_cpl_data),
        .empty(cpl_empty)
        );

endmodule

// ==== design/host_chan_settings.svh ====
/*
 * Build-time sizing for the emulated host channel.
 * NUM_TAGS and FIFO_DEPTH must be powers of two and at least 2.
 * FIFO_DEPTH must be no smaller than NUM_TAGS so that completions never overflow.
 */
`ifndef HOST_CHAN_SETTINGS_SVH
`define HOST_CHAN_SETTINGS_SVH

// Ports that receive clock, reset and instance number
`define HOST_CHAN_NUM_PORTS 2
// Reads that may be outstanding at once
`define HOST_CHAN_NUM_TAGS 4
// Entries in each packet FIFO
`define HOST_CHAN_FIFO_DEPTH 8
// 64-bit registers in the AFU endpoint, register 0 included
`define HOST_CHAN_NUM_REGS 8
// Cycles that soft reset lingers once the primary reset is gone
`define HOST_CHAN_SOFT_RESET_CYCLES 8

`endif

// ==== design/host_chan_top.sv ====
/*
 * Top level joining the host channel emulator to the AFU register endpoint.
 * reset is synchronous to pClk and active high.
 */
`timescale 1ns/1ns
`include "host_chan_settings.svh"

module host_chan_top
   (
    input  logic                       pClk,
    input  logic                       reset,

    input  logic                       cmd_valid,
    input  logic                       cmd_write,
    input  tlp_pkg::t_reg_addr         cmd_addr,
    input  logic [63:0]                cmd_data,
    output logic                       cmd_full,

    output logic                       rd_valid,
    output tlp_pkg::t_tlp_tag          rd_tag,
    output logic [63:0]                rd_data,

    output logic                       soft_reset,
    output platform_pkg::t_power_state pwr_state,
    output logic [`HOST_CHAN_NUM_PORTS-1:0] port_reset_n,
    output platform_pkg::t_port_num [`HOST_CHAN_NUM_PORTS-1:0] port_instance
    );

    platform_pkg::t_std_clocks clocks;
    logic                      req_empty;
    logic                      req_pop;
    tlp_pkg::t_tlp_req         req_data;
    logic                      cpl_push;
    tlp_pkg::t_tlp_cpl         cpl_data;

    // Primary clock and its reset travel together into the emulator
    assign clocks.pClk.clk   = pClk;
    assign clocks.pClk.reset = reset;

    host_chan_emul emul
       (
        .clocks(clocks),
        .cmd_valid(cmd_valid),
        .cmd_write(cmd_write),
        .cmd_addr(cmd_addr),
        .cmd_data(cmd_data),
        .cmd_full(cmd_full),
        .req_empty(req_empty),
        .req_pop(req_pop),
        .req_data(req_data),
        .cpl_push(cpl_push),
        .cpl_data(cpl_data),
        .rd_valid(rd_valid),
        .rd_tag(rd_tag),
        .rd_data(rd_data),
        .soft_reset(soft_reset),
        .pwr_state(pwr_state),
        .port_reset_n(port_reset_n),
        .port_instance(port_instance)
        );

    afu_csr_endpoint endpoint
       (
        .pClk(pClk),
        .reset(reset),
        .req_empty(req_empty),
        .req_pop(req_pop),
        .req_data(req_data),
        .cpl_push(cpl_push),
        .cpl_data(cpl_data)
        );

endmodule

// ==== design/platform_pkg.sv ====
/*
 * Platform-level types shared by the host emulator and the top level.
 * Only the primary clock is modelled.
 */
package platform_pkg;

    // One clock with the reset that is synchronous to it
    typedef struct packed {
        logic clk;
        logic reset;
    } t_clock_reset;

    // Clock bundle handed to the emulator with pClk as the primary clock
    typedef struct packed {
        t_clock_reset pClk;
    } t_std_clocks;

    // Power state reported to the AFU
    typedef enum logic [1:0] {
        power_normal = 2'h0,
        power_reset  = 2'h1
    } t_power_state;

    // Instance number of one host channel port for up to 16 ports
    typedef logic [3:0] t_port_num;

endpackage

// ==== design/tlp_fifo.sv ====
/*
 * Synchronous circular-buffer FIFO for one packet type.
 * pop_data shows the head entry whenever empty is low; it is not valid otherwise.
 * Callers must not push when full or pop when empty.
 */
`timescale 1ns/1ns
`include "host_chan_settings.svh"

module tlp_fifo
  #(
    parameter type t_payload = logic
    )
   (
    input  logic     pClk,
    input  logic     reset,
    input  logic     push,
    input  t_payload push_data,
    input  logic     pop,
    output t_payload pop_data,
    output logic     empty
    );

    localparam int DEPTH = `HOST_CHAN_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    t_payload         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;

    assign empty    = (count == '0);
    assign full     = (count == (PTR_W + 1)'(DEPTH));
    // Head of queue is visible the cycle after the push that wrote it
    assign pop_data = mem[rd_ptr];

    // Entry storage is written on every push
    always_ff @(posedge pClk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge pClk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // A simultaneous push and pop leaves the occupancy unchanged
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The tag limit upstream keeps this queue from ever filling
    assert property (@(posedge pClk) disable iff (reset) !(push && full));
    // Consumers only pop a queue that has something in it
    assert property (@(posedge pClk) disable iff (reset) !(pop && empty));

endmodule

// ==== design/tlp_host_model.sv ====
/*
 * Host side of the emulated channel with soft-reset sequencing, power state,
 * read tag allocation, request packet formation and completion return.
 * Completions must come back in request order. Commands are ignored
 * while soft_reset is high, and none may be presented while cmd_full is high.
 */
`timescale 1ns/1ns
`include "host_chan_settings.svh"

module tlp_host_model
   (
    input  logic                      pClk,
    input  logic                      reset,

    input  logic                      cmd_valid,
    input  logic                      cmd_write,
    input  tlp_pkg::t_reg_addr        cmd_addr,
    input  logic [63:0]               cmd_data,
    output logic                      cmd_full,

    output logic                      req_push,
    output tlp_pkg::t_tlp_req         req_data,

    input  logic                      cpl_empty,
    output logic                      cpl_pop,
    input  tlp_pkg::t_tlp_cpl         cpl_data,

    output logic                      rd_valid,
    output tlp_pkg::t_tlp_tag         rd_tag,
    output logic [63:0]               rd_data,

    output logic                      soft_reset,
    output platform_pkg::t_power_state pwr_state
    );

    localparam int NUM_TAGS = `HOST_CHAN_NUM_TAGS;
    localparam int SR_CYCLES = `HOST_CHAN_SOFT_RESET_CYCLES;
    localparam int SR_W = $clog2(SR_CYCLES + 1);

    logic [SR_W-1:0]     sr_count;
    logic [NUM_TAGS-1:0] busy;
    logic [NUM_TAGS-1:0] busy_set;
    logic [NUM_TAGS-1:0] busy_clr;
    tlp_pkg::t_tlp_tag   next_tag;
    logic                cmd_accept;
    logic                rd_issue;

    // Soft reset holds while the countdown is still running
    assign soft_reset = (sr_count != '0);
    assign pwr_state  = soft_reset ? platform_pkg::power_reset : platform_pkg::power_normal;

    always_ff @(posedge pClk)
    begin
        if (reset)
            sr_count <= SR_W'(SR_CYCLES);
        else if (sr_count != '0)
            sr_count <= sr_count - 1'b1;
    end

    assign cmd_accept = cmd_valid && !soft_reset;
    assign rd_issue   = cmd_accept && !cmd_write;

    // Every tag in flight means no room for another read
    assign cmd_full = &busy;
    // Completions are drained as soon as they arrive
    assign cpl_pop  = !cpl_empty;

    always_comb
    begin
        busy_set = '0;
        busy_clr = '0;
        if (rd_issue)
            busy_set[next_tag] = 1'b1;
        if (cpl_pop)
            busy_clr[cpl_data.hdr.tag] = 1'b1;
    end

    always_ff @(posedge pClk)
    begin
        if (reset)
        begin
            busy     <= '0;
            next_tag <= '0;
            req_push <= 1'b0;
            rd_valid <= 1'b0;
        end
        else
        begin
            busy     <= (busy | busy_set) & ~busy_clr;
            req_push <= cmd_accept;
            // Tags are handed out in rotation and writes take none
            if (rd_issue)
                next_tag <= next_tag + 1'b1;
            // The tag is freed on the same edge that raises rd_valid
            rd_valid <= cpl_pop;
        end
    end

    // Request packet fields follow the command and read data follows the completion
    always_ff @(posedge pClk)
    begin
        req_data.hdr.kind <= cmd_write ? tlp_pkg::mem_write : tlp_pkg::mem_read;
        req_data.hdr.tag  <= cmd_write ? '0 : next_tag;
        req_data.hdr.addr <= cmd_addr;
        req_data.data     <= cmd_write ? cmd_data : '0;
        rd_tag            <= cpl_data.hdr.tag;
        rd_data           <= cpl_data.data;
    end

    // Senders respect back-pressure
    assert property (@(posedge pClk) disable iff (reset) cmd_valid |-> !cmd_full);
    // The endpoint only answers reads that this model issued
    assert property (@(posedge pClk) disable iff (reset) cpl_pop |-> busy[cpl_data.hdr.tag]);

endmodule

// ==== design/tlp_pkg.sv ====
/*
 * Packet formats for the simplified memory-mapped TLP path.
 * Payloads are always a single 64-bit word with no byte enables.
 */
`include "host_chan_settings.svh"

package tlp_pkg;

    // Field widths derived from the build-time sizing
    localparam int TAG_WIDTH  = $clog2(`HOST_CHAN_NUM_TAGS);
    localparam int ADDR_WIDTH = $clog2(`HOST_CHAN_NUM_REGS);

    typedef logic [TAG_WIDTH-1:0]  t_tlp_tag;
    typedef logic [ADDR_WIDTH-1:0] t_reg_addr;

    // Value that register 0 of the endpoint always returns
    localparam logic [63:0] AFU_ID = 64'h5a3c_0f1e_8d26_b947;

    // Packet kinds carried on the channel
    typedef enum logic [1:0] {
        mem_read   = 2'h0,
        mem_write  = 2'h1,
        completion = 2'h2
    } t_tlp_kind;

    // Header common to requests and completions
    typedef struct packed {
        t_tlp_kind kind;
        t_tlp_tag  tag;
        t_reg_addr addr;
    } t_tlp_hdr;

    // Host to AFU request whose data is only meaningful for writes
    typedef struct packed {
        t_tlp_hdr    hdr;
        logic [63:0] data;
    } t_tlp_req;

    // AFU to host completion of a read
    typedef struct packed {
        t_tlp_hdr    hdr;
        logic [63:0] data;
    } t_tlp_cpl;

endpackage

// ==== flist.f ====
+incdir+design
design/platform_pkg.sv
design/tlp_pkg.sv
design/tlp_fifo.sv
design/tlp_host_model.sv
design/afu_csr_endpoint.sv
design/host_chan_emul.sv
design/host_chan_top.sv
tests/host_chan_checker.sv
tests/tb_host_chan.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the host channel testbench with Verilator, runs it into sim.log
# and fails when the log reports a failing result.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module tb_host_chan \
    -Mdir obj_dir -o sim_host_chan > build.log 2>&1 &&
./obj_dir/sim_host_chan > sim.log 2>&1 ||
{ echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "failures found in sim.log"; exit 1; } || exit 0

// ==== tests/host_chan_checker.sv ====
/*
 * Watches the host channel top level and compares it cycle by cycle.
 * Expected reads arrive through exp_push in issue order with their tag and data.
 * Samples on the rising edge, so inputs must change on the falling edge.
 */
`timescale 1ns/1ns
`include "host_chan_settings.svh"

module host_chan_checker
   (
    input  logic                       pClk,
    input  logic                       reset,

    input  logic                       exp_push,
    input  tlp_pkg::t_tlp_tag          exp_tag,
    input  logic [63:0]                exp_data,

    input  logic                       cmd_full,
    input  logic                       rd_valid,
    input  tlp_pkg::t_tlp_tag          rd_tag,
    input  logic [63:0]                rd_data,
    input  logic                       soft_reset,
    input  platform_pkg::t_power_state pwr_state,
    input  logic [`HOST_CHAN_NUM_PORTS-1:0] port_reset_n,
    input  platform_pkg::t_port_num [`HOST_CHAN_NUM_PORTS-1:0] port_instance,

    output int                         checks,
    output int                         errors,
    output int                         pending
    );

    localparam int NUM_PORTS = `HOST_CHAN_NUM_PORTS;
    localparam int NUM_TAGS  = `HOST_CHAN_NUM_TAGS;
    localparam int SR_CYCLES = `HOST_CHAN_SOFT_RESET_CYCLES;

    // One read that is still waiting for its completion
    typedef struct packed {
        tlp_pkg::t_tlp_tag tag;
        logic [63:0]       data;
    } t_expect;

    t_expect exp_q [$];
    t_expect head;
    int      low_edges;
    int      outstanding;
    logic    seen_reset;
    logic    in_soft;

    initial
    begin
        checks     = 0;
        errors     = 0;
        pending    = 0;
        low_edges  = 0;
        seen_reset = 1'b0;
    end

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    always @(posedge pClk)
    begin
        // Soft reset covers the reset cycles and SR_CYCLES edges after them
        in_soft = (low_edges < SR_CYCLES);
        if (seen_reset)
        begin
            compare_value("soft_reset", in_soft, soft_reset);
            compare_value("pwr_state",
                          in_soft ? platform_pkg::power_reset : platform_pkg::power_normal,
                          pwr_state);
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                compare_value($sformatf("port_reset_n[%0d]", p), !in_soft, port_reset_n[p]);
                compare_value($sformatf("port_instance[%0d]", p), p, port_instance[p]);
            end
        end

        if (reset)
        begin
            exp_q.delete();
            low_edges  = 0;
            seen_reset = 1'b1;
        end
        else
        begin
            if (low_edges <= SR_CYCLES)
                low_edges++;
            // A returning read already gave its tag back on this cycle
            outstanding = exp_q.size() - (rd_valid ? 1 : 0);
            compare_value("cmd_full", (outstanding == NUM_TAGS), cmd_full);

            if (rd_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("%0t ns: rd_valid arrived with no read outstanding", $time);
                end
                else
                begin
                    // Completions come back strictly in request order
                    head = exp_q.pop_front();
                    compare_value("rd_tag", head.tag, rd_tag);
                    compare_value("rd_data", head.data, rd_data);
                end
            end

            if (exp_push)
                exp_q.push_back('{tag: exp_tag, data: exp_data});
        end
        pending = exp_q.size();
    end

endmodule

// ==== tests/tb_host_chan.sv ====
/*
 * Testbench for the emulated host channel with the AFU register endpoint.
 * Covers soft-reset sequencing, register writes and reads, the ID register,
 * tag back-pressure and a random command mix. Commands wait for cmd_full low.
 */
`timescale 1ns/1ns
`include "host_chan_settings.svh"

module tb_host_chan;

    localparam int NUM_REGS   = `HOST_CHAN_NUM_REGS;
    localparam int NUM_TAGS   = `HOST_CHAN_NUM_TAGS;
    localparam int SR_CYCLES  = `HOST_CHAN_SOFT_RESET_CYCLES;
    localparam int RANDOM_OPS = 200;
    // Longest wait for any single event before it counts as lost
    localparam int WAIT_LIMIT = 50;
    // Cycles for reset, soft reset, register test, ID test, back-to-back reads
    // and the random mix, every command allowed to stall behind a full tag set
    localparam int TEST_CYCLES = 16 + (SR_CYCLES + 2)
        + (2 * NUM_REGS * (NUM_TAGS + 1) + WAIT_LIMIT)
        + (3 * (NUM_TAGS + 1) + WAIT_LIMIT)
        + ((NUM_TAGS + 2) * (NUM_TAGS + 1) + WAIT_LIMIT)
        + (RANDOM_OPS * (NUM_TAGS + 1) + WAIT_LIMIT);
    localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * 100;

    logic               pClk;
    logic               reset;
    logic               cmd_valid;
    logic               cmd_write;
    tlp_pkg::t_reg_addr cmd_addr;
    logic [63:0]        cmd_data;
    logic               cmd_full;
    logic               rd_valid;
    tlp_pkg::t_tlp_tag  rd_tag;
    logic [63:0]        rd_data;
    logic               soft_reset;
    platform_pkg::t_power_state pwr_state;
    logic [`HOST_CHAN_NUM_PORTS-1:0] port_reset_n;
    platform_pkg::t_port_num [`HOST_CHAN_NUM_PORTS-1:0] port_instance;

    logic               exp_push;
    tlp_pkg::t_tlp_tag  exp_tag;
    logic [63:0]        exp_data;
    int                 chk_checks;
    int                 chk_errors;
    int                 pending;

    integer             seed = 32'h0941d43e;
    logic [63:0]        model_regs [NUM_REGS];
    tlp_pkg::t_tlp_tag  tag_count;
    int                 tb_checks;
    int                 tb_errors;
    int                 checks_before;
    int                 errors_before;
    int                 cycles;
    logic [31:0]        rnd;
    logic               full_seen;

    host_chan_top u_host_chan_top
       (
        .pClk(pClk),
        .reset(reset),
        .cmd_valid(cmd_valid),
        .cmd_write(cmd_write),
        .cmd_addr(cmd_addr),
        .cmd_data(cmd_data),
        .cmd_full(cmd_full),
        .rd_valid(rd_valid),
        .rd_tag(rd_tag),
        .rd_data(rd_data),
        .soft_reset(soft_reset),
        .pwr_state(pwr_state),
        .port_reset_n(port_reset_n),
        .port_instance(port_instance)
        );

    host_chan_checker result_check
       (
        .pClk(pClk),
        .reset(reset),
        .exp_push(exp_push),
        .exp_tag(exp_tag),
        .exp_data(exp_data),
        .cmd_full(cmd_full),
        .rd_valid(rd_valid),
        .rd_tag(rd_tag),
        .rd_data(rd_data),
        .soft_reset(soft_reset),
        .pwr_state(pwr_state),
        .port_reset_n(port_reset_n),
        .port_instance(port_instance),
        .checks(chk_checks),
        .errors(chk_errors),
        .pending(pending)
        );

    initial
        pClk = 1'b0;
    always #50 pClk = ~pClk;

    // Register 0 is the fixed ID, every other register holds its last write
    function automatic logic [63:0] expected_read(input tlp_pkg::t_reg_addr addr);
        if (addr == '0)
            return tlp_pkg::AFU_ID;
        return model_regs[addr];
    endfunction

    // Presents one command for a single cycle, starting on a falling edge
    task automatic issue_cmd(input logic write, input tlp_pkg::t_reg_addr addr,
                             input logic [63:0] data);
        int waited;
        waited = 0;
        while (cmd_full && waited < WAIT_LIMIT)
        begin
            @(negedge pClk);
            waited++;
        end
        if (cmd_full)
        begin
            tb_errors++;
            $display("%0t ns: cmd_full never fell, command dropped", $time);
            return;
        end
        cmd_valid = 1'b1;
        cmd_write = write;
        cmd_addr  = addr;
        cmd_data  = data;
        if (!write)
        begin
            // Tags are handed out in rotation, one per read
            exp_push  = 1'b1;
            exp_tag   = tag_count;
            exp_data  = expected_read(addr);
            tag_count = tag_count + 1'b1;
        end
        else if (addr != '0)
            model_regs[addr] = data;
        @(negedge pClk);
        cmd_valid = 1'b0;
        exp_push  = 1'b0;
    endtask

    // Waits for every issued read to come back
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending != 0 && waited < WAIT_LIMIT)
        begin
            @(negedge pClk);
            waited++;
        end
        if (pending != 0)
        begin
            tb_errors++;
            $display("%0t ns: %0d reads never completed", $time, pending);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s done: %0d checks, %0d errors", name,
                 chk_checks + tb_checks - checks_before,
                 chk_errors + tb_errors - errors_before);
        checks_before = chk_checks + tb_checks;
        errors_before = chk_errors + tb_errors;
    endtask

    initial
    begin
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_addr  = '0;
        cmd_data  = '0;
        exp_push  = 1'b0;
        exp_tag   = '0;
        exp_data  = '0;
        tag_count = '0;
        tb_checks = 0;
        tb_errors = 0;
        checks_before = 0;
        errors_before = 0;
        for (int i = 0; i < NUM_REGS; i++)
            model_regs[i] = '0;

        repeat (16) @(negedge pClk);
        reset = 1'b0;

        // Count the edges until soft reset lets go
        cycles = 0;
        do
        begin
            @(negedge pClk);
            cycles++;
        end
        while (soft_reset && cycles < WAIT_LIMIT);
        tb_checks++;
        if (cycles != SR_CYCLES)
        begin
            tb_errors++;
            $display("mismatch at %0t ns: soft_reset cycles expected %0d, got %0d",
                     $time, SR_CYCLES, cycles);
        end
        finish_test("1 soft reset");

        // The two highest registers stay unwritten and must read 0
        for (int i = 1; i < NUM_REGS - 2; i++)
            issue_cmd(1'b1, tlp_pkg::t_reg_addr'(i), {$random(seed), $random(seed)});
        for (int i = 1; i < NUM_REGS; i++)
            issue_cmd(1'b0, tlp_pkg::t_reg_addr'(i), '0);
        wait_drain();
        finish_test("2 register write and read");

        issue_cmd(1'b0, '0, '0);
        issue_cmd(1'b1, '0, {$random(seed), $random(seed)});
        issue_cmd(1'b0, '0, '0);
        wait_drain();
        finish_test("3 ID register");

        full_seen = 1'b0;
        for (int i = 0; i < NUM_TAGS + 2; i++)
        begin
            issue_cmd(1'b0, tlp_pkg::t_reg_addr'(i % NUM_REGS), '0);
            if (cmd_full)
                full_seen = 1'b1;
        end
        tb_checks++;
        if (!full_seen)
        begin
            tb_errors++;
            $display("%0t ns: cmd_full never rose with every tag outstanding", $time);
        end
        wait_drain();
        finish_test("4 back-to-back reads");

        for (int i = 0; i < RANDOM_OPS; i++)
        begin
            rnd = $random(seed);
            issue_cmd(rnd[0], tlp_pkg::t_reg_addr'(rnd[31:1] % NUM_REGS),
                      {$random(seed), $random(seed)});
        end
        wait_drain();
        finish_test("5 random mix");

        $display("summary: %0d checks, %0d errors", chk_checks + tb_checks,
                 chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // Ends a run that outlasts the summed test lengths
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
